// ==== flist.f ====
ulpiPkg.sv
ulpiBusIf.sv
ulpiFifo.sv
ulpiRegWrite.sv
ulpiRegRead.sv
ulpiReceiver.sv
ulpiLink.sv
tbClock.sv
ulpiPhyModel.sv
ulpiLinkTb.sv

// ==== ulpiLinkTb.sv ====
// Testbench top for the ULPI link, directed tests against a behavioral PHY
// Prints an error count and a pass or fail line at the end
`timescale 1ns/1ps
`default_nettype none

module ulpiLinkTb import ulpiPkg::*;;
    localparam int LIMIT = 3000; // About five times the test length

    logic clk, rst;
    logic regWriteReq, regReadReq, dataRe, infoRe;
    logic [5:0] regAddr;
    logic [7:0] regWriteVal, regReadVal, rxCmd, usbData, dataIn, dataOut;
    logic [2:0] status;
    logic [1:0] lineState, vbusState;
    logic rxActive, rxError, hostDisconnect, rxId;
    logic dataFull, dataEmpty, infoFull, infoEmpty;
    logic dir, nxt, stp, phyRst;
    infoWordT usbInfo;
    logic [7:0] expRegs [64]; // Expected PHY register file
    logic [7:0] expQ [$];     // Expected data bytes
    integer seed;
    int errors = 0;
    int cycles = 0;

    tbClock clkGen (.clk(clk), .rst(rst));
    ulpiPhyModel phy (.clk(clk), .dataOut(dataOut), .stp(stp), .dir(dir), .nxt(nxt),
        .dataIn(dataIn));
    ulpiLink #(.DATA_DEPTH(16), .INFO_DEPTH(4)) UUT (
        .clk_ULPI(clk), .rst(rst), .regWriteReq(regWriteReq), .regReadReq(regReadReq),
        .regAddr(regAddr), .regWriteVal(regWriteVal), .regReadVal(regReadVal),
        .status(status), .rxCmd(rxCmd), .lineState(lineState), .vbusState(vbusState),
        .rxActive(rxActive), .rxError(rxError), .hostDisconnect(hostDisconnect),
        .rxId(rxId), .dataRe(dataRe), .infoRe(infoRe), .usbData(usbData),
        .usbInfo(usbInfo), .dataFull(dataFull), .dataEmpty(dataEmpty),
        .infoFull(infoFull), .infoEmpty(infoEmpty), .dir(dir), .nxt(nxt),
        .dataIn(dataIn), .dataOut(dataOut), .stp(stp), .phyRst(phyRst));

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == LIMIT) begin
            $display("Timeout after %0d cycles, DUT stopped responding", LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic checkVal(input string test, input logic [31:0] exp, input logic [31:0] act);
        assert (exp == act) else begin
            $display("Fail %s expected %0h actual %0h", test, exp, act);
            errors++;
        end
    endtask

    task automatic waitIdle();
        @(negedge clk);
        while (status != IDLE) @(negedge clk); // Engine or receive still running
    endtask

    task automatic checkRegs(input string test);
        for (int i = 0; i < 64; i++) checkVal(test, expRegs[i], phy.regs[i]);
    endtask

    task automatic writeReg(input logic [5:0] a, input logic [7:0] v);
        @(posedge clk) begin
            regAddr     <= a;
            regWriteVal <= v;
            regWriteReq <= 1'b1;
        end
        @(posedge clk) regWriteReq <= 1'b0;
        @(negedge clk) checkVal("testRegWrite status", REG_WRITE, status);
        waitIdle();
        expRegs[a] = v;
    endtask

    task automatic readReg(input logic [5:0] a);
        @(posedge clk) begin
            regAddr    <= a;
            regReadReq <= 1'b1;
        end
        @(posedge clk) regReadReq <= 1'b0;
        waitIdle();
        checkVal("testRegRead", expRegs[a], regReadVal);
    endtask

    task automatic popByte(output logic [7:0] b);
        @(posedge clk) dataRe <= 1'b1;
        @(posedge clk) dataRe <= 1'b0;
        @(negedge clk) b = usbData; // Registered read
    endtask

    task automatic popInfo(output infoWordT w);
        @(posedge clk) infoRe <= 1'b1;
        @(posedge clk) infoRe <= 1'b0;
        @(negedge clk) w = usbInfo;
    endtask

    task automatic playPacket(input int len);
        logic [7:0] b;
        for (int i = 0; i < len; i++) begin
            b = $random(seed);
            phy.pktBuf[i] = b;
            if (expQ.size() < 16) expQ.push_back(b); // Depth limits storage
        end
        phy.sendPacket(len);
        waitIdle();
    endtask

    task automatic testReset();
        @(negedge clk); // Still in reset
        checkVal("testReset stp", 0, stp);
        checkVal("testReset dataOut", 0, dataOut);
        checkVal("testReset phyRst", 1, phyRst);
        checkVal("testReset status", START, status);
        wait (rst);
        phy.releaseBus();
        @(negedge clk) checkVal("testReset start", START, status); // dir low not yet clocked
        @(negedge clk) checkVal("testReset idle", IDLE, status);
    endtask

    task automatic testRegWrite();
        writeReg(6'h04, 8'hA5);
        writeReg(6'h16, 8'h3C);
        writeReg(6'h0A, 8'hC3);
        checkRegs("testRegWrite regs");
    endtask

    task automatic testRegRead();
        readReg(6'h04);
        readReg(6'h16);
        readReg(6'h0A);
        readReg(6'h3F); // Never written
    endtask

    task automatic testRxCmd();
        logic [7:0] cmds [5];
        logic [1:0] evt;
        cmds = '{8'h15, 8'h3A, 8'h00, 8'h6F, 8'h47};
        foreach (cmds[i]) begin
            phy.sendRxCmd(cmds[i]);
            waitIdle();
            evt = cmds[i][RX_EVENT_MSB:RX_EVENT_LSB];
            checkVal("testRxCmd rxCmd", cmds[i], rxCmd);
            checkVal("testRxCmd lineState", cmds[i][1:0], lineState);
            checkVal("testRxCmd vbusState", cmds[i][3:2], vbusState);
            checkVal("testRxCmd rxActive", evt == 2'b01 || evt == 2'b11, rxActive);
            checkVal("testRxCmd rxError", evt == 2'b11, rxError);
            checkVal("testRxCmd hostDisconnect", evt == 2'b10, hostDisconnect);
            checkVal("testRxCmd rxId", cmds[i][6], rxId);
        end
    endtask

    task automatic testPacket();
        logic [7:0] b;
        infoWordT w;
        playPacket(5);
        playPacket(9);
        checkVal("testPacket infoEmpty", 0, infoEmpty);
        checkVal("testPacket infoFull", 0, infoFull);
        for (int i = 0; i < 14; i++) begin
            popByte(b);
            checkVal("testPacket data", expQ.pop_front(), b);
        end
        popInfo(w);
        checkVal("testPacket count1", 5, w.byteCount);
        checkVal("testPacket error1", 0, w.errorSeen);
        checkVal("testPacket lineState1", 2'b01, w.lineStateAtEnd); // Closing RX CMD is J
        popInfo(w);
        checkVal("testPacket count2", 9, w.byteCount);
        checkVal("testPacket error2", 0, w.errorSeen);
        playPacket(20); // Overflows 16-deep data FIFO
        checkVal("testPacket dataFull", 1, dataFull);
        popInfo(w);
        checkVal("testPacket overflow count", 20, w.byteCount);
        checkVal("testPacket overflow error", 1, w.errorSeen);
        for (int i = 0; i < 16; i++) begin
            popByte(b);
            checkVal("testPacket overflow data", expQ.pop_front(), b);
        end
        checkVal("testPacket dataEmpty", 1, dataEmpty);
        checkVal("testPacket infoEmpty drained", 1, infoEmpty);
    endtask

    task automatic testPriority();
        for (int i = 0; i < 3; i++) phy.pktBuf[i] = $random(seed);
        fork
            phy.sendPacket(3);
            begin
                repeat (3) @(posedge clk);
                regAddr     <= 6'h20;
                regWriteVal <= 8'h5A;
                regWriteReq <= 1'b1;
                @(negedge clk) checkVal("testPriority status", RECV, status);
                @(posedge clk) regWriteReq <= 1'b0; // Dropped while dir high
            end
        join
        waitIdle();
        for (int i = 0; i < 8; i++) begin
            @(negedge clk) checkVal("testPriority held", IDLE, status); // No queued write
        end
        checkRegs("testPriority unchanged");
        writeReg(6'h20, 8'h5A); // Now in IDLE
        checkRegs("testPriority write");
    endtask

    initial begin
        seed        = 32'hf838_0670;
        regWriteReq = 1'b0;
        regReadReq  = 1'b0;
        regAddr     = 6'h00;
        regWriteVal = 8'h00;
        dataRe      = 1'b0;
        infoRe      = 1'b0;
        for (int i = 0; i < 64; i++) expRegs[i] = 8'h00;
        testReset();
        testRegWrite();
        testRegRead();
        testRxCmd();
        testPacket();
        testPriority();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end
endmodule

`default_nettype wire

// ==== ulpiPhyModel.sv ====
// Behavioral ULPI PHY with a register file, read turnaround and scripted receive
// The testbench calls its tasks to play RX CMDs and packets
`timescale 1ns/1ps
`default_nettype none

module ulpiPhyModel (
    input  logic       clk,
    input  logic [7:0] dataOut,
    input  logic       stp,
    output logic       dir,
    output logic       nxt,
    output logic [7:0] dataIn
);
    logic [7:0] regs [64];   // PHY registers, reset value 0
    logic [7:0] pktBuf [32]; // Bytes for the next packet
    logic [5:0] addr;
    int         phase;

    initial begin
        dir    = 1'b1; // PHY holds the bus until released
        nxt    = 1'b0;
        dataIn = 8'h00;
        phase  = 0;
        for (int i = 0; i < 64; i++) regs[i] = 8'h00;
    end

    // Answers TX CMDs from the link
    always @(posedge clk) begin
        case (phase)
            0: if (!dir && dataOut[7] == 1'b1) begin
                addr  <= dataOut[5:0];
                nxt   <= 1'b1; // Accept command
                phase <= dataOut[6] ? 10 : 1;
            end
            1: phase <= 2; // Engine moves to data byte
            2: begin
                regs[addr] <= dataOut; // Value byte
                nxt        <= 1'b0;
                phase      <= 3;
            end
            3: if (stp) phase <= 0;
            10: begin
                nxt   <= 1'b0;
                dir   <= 1'b1; // Turnaround cycle
                phase <= 11;
            end
            11: begin
                dataIn <= regs[addr];
                phase  <= 12;
            end
            12: begin
                dir    <= 1'b0; // Hand bus back
                dataIn <= 8'h00;
                phase  <= 0;
            end
            default: phase <= 0;
        endcase
    end

    task automatic releaseBus();
        @(posedge clk) dir <= 1'b0;
    endtask

    // Turnaround, one RX CMD, then release
    task automatic sendRxCmd(input logic [7:0] cmd);
        @(posedge clk) begin dir <= 1'b1; nxt <= 1'b0; dataIn <= 8'h00; end
        @(posedge clk) dataIn <= cmd;
        @(posedge clk) begin dir <= 1'b0; dataIn <= 8'h00; end
    endtask

    // RxActive, len bytes from pktBuf, RxActive cleared
    task automatic sendPacket(input int len);
        @(posedge clk) begin dir <= 1'b1; nxt <= 1'b0; dataIn <= 8'h00; end
        @(posedge clk) dataIn <= 8'h11; // RxActive, LineState J
        for (int i = 0; i < len; i++) begin
            @(posedge clk) begin nxt <= 1'b1; dataIn <= pktBuf[i]; end
        end
        @(posedge clk) begin nxt <= 1'b0; dataIn <= 8'h01; end // Event none
        @(posedge clk) begin dir <= 1'b0; dataIn <= 8'h00; end
    endtask
endmodule

`default_nettype wire

// ==== tbClock.sv ====
// Testbench clock and reset source for the ULPI link
// 10 ns clock, active-low reset held for two cycles
`timescale 1ns/1ps
`default_nettype none

module tbClock (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        rst = 1'b0; // Reset asserted from time zero
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (2) @(posedge clk);
        rst <= 1'b1; // Release after two edges
    end
endmodule

`default_nettype wire

// ==== ulpiLink.sv ====
// ULPI link top, arbitrates the PHY bus between write, read and receive engines
// Inout data bus is split here, the tristate lives in the board wrapper
`timescale 1ns/1ps
`default_nettype none

module ulpiLink import ulpiPkg::*; #(
    parameter int DATA_DEPTH = 16,
    parameter int INFO_DEPTH = 4
) (
    input  logic       clk_ULPI,
    input  logic       rst,
    input  logic       regWriteReq,
    input  logic       regReadReq,
    input  logic [5:0] regAddr,
    input  logic [7:0] regWriteVal,
    output logic [7:0] regReadVal,
    output logic [2:0] status,
    output logic [7:0] rxCmd,
    output logic [1:0] lineState,
    output logic [1:0] vbusState,
    output logic       rxActive,
    output logic       rxError,
    output logic       hostDisconnect,
    output logic       rxId,
    input  logic       dataRe,
    input  logic       infoRe,
    output logic [7:0] usbData,
    output infoWordT   usbInfo,
    output logic       dataFull,
    output logic       dataEmpty,
    output logic       infoFull,
    output logic       infoEmpty,
    input  logic       dir,
    input  logic       nxt,
    input  logic [7:0] dataIn,
    output logic [7:0] dataOut,
    output logic       stp,
    output logic       phyRst
);
    linkStateT state;
    logic      wrStart;
    logic      rdStart;
    logic      wrBusy;
    logic      rdBusy;
    logic      rxBusy;
    logic      isIdle;

    ulpiBusIf wrBus ();
    ulpiBusIf rdBus ();
    ulpiBusIf rxBus ();

    assign wrBus.dir    = dir; // Every engine sees the PHY inputs
    assign wrBus.nxt    = nxt;
    assign wrBus.dataIn = dataIn;
    assign rdBus.dir    = dir;
    assign rdBus.nxt    = nxt;
    assign rdBus.dataIn = dataIn;
    assign rxBus.dir    = dir;
    assign rxBus.nxt    = nxt;
    assign rxBus.dataIn = dataIn;

    // Requests only count in IDLE with the bus free, never queued
    assign isIdle  = (state == IDLE) && !dir && !rxBusy;
    assign wrStart = isIdle && regWriteReq;
    assign rdStart = isIdle && regReadReq && !regWriteReq; // Write wins

    always_ff @(posedge clk_ULPI) begin
        if (!rst) begin
            state <= START;
        end else begin
            case (state)
                START:     if (!dir) state <= IDLE; // PHY released bus
                IDLE: begin
                    if (rxBusy) state <= RECV;
                    else if (wrStart) state <= REG_WRITE;
                    else if (rdStart) state <= REG_READ;
                end
                RECV:      if (!rxBusy) state <= IDLE;
                REG_WRITE: if (!wrBusy) state <= IDLE;
                REG_READ:  if (!rdBusy) state <= IDLE;
                default:   state <= IDLE;
            endcase
        end
    end

    // Bus goes to whichever engine owns the current state
    always_comb begin
        case (state)
            REG_WRITE: begin
                dataOut = wrBus.dataOut;
                stp     = wrBus.stp;
            end
            REG_READ: begin
                dataOut = rdBus.dataOut;
                stp     = rdBus.stp;
            end
            RECV: begin
                dataOut = rxBus.dataOut;
                stp     = rxBus.stp;
            end
            default: begin
                dataOut = '0; // START and IDLE
                stp     = 1'b0;
            end
        endcase
    end

    assign status = state;
    assign phyRst = ~rst; // PHY reset is active high

    ulpiRegWrite regWrite (
        .clk_ULPI(clk_ULPI),
        .rst     (rst),
        .start   (wrStart),
        .regAddr (regAddr),
        .regVal  (regWriteVal),
        .busy    (wrBusy),
        .bus     (wrBus)
    );

    ulpiRegRead regRead (
        .clk_ULPI(clk_ULPI),
        .rst     (rst),
        .start   (rdStart),
        .regAddr (regAddr),
        .regVal  (regReadVal),
        .busy    (rdBusy),
        .bus     (rdBus)
    );

    ulpiReceiver #(
        .DATA_DEPTH(DATA_DEPTH),
        .INFO_DEPTH(INFO_DEPTH)
    ) receiver (
        .clk_ULPI      (clk_ULPI),
        .rst           (rst),
        .readAllow     (state == IDLE || state == RECV),
        .busy          (rxBusy),
        .bus           (rxBus),
        .rxCmd         (rxCmd),
        .lineState     (lineState),
        .vbusState     (vbusState),
        .rxActive      (rxActive),
        .rxError       (rxError),
        .hostDisconnect(hostDisconnect),
        .rxId          (rxId),
        .dataRe        (dataRe),
        .infoRe        (infoRe),
        .usbData       (usbData),
        .usbInfo       (usbInfo),
        .dataFull      (dataFull),
        .dataEmpty     (dataEmpty),
        .infoFull      (infoFull),
        .infoEmpty     (infoEmpty)
    );

    // Engines never overlap except a receive that starts while others idle
    assert property (@(posedge clk_ULPI) disable iff (!rst)
        (state != RECV) |-> $onehot0({wrBusy, rdBusy, rxBusy}));

endmodule

`default_nettype wire

// ==== ulpiReceiver.sv ====
// ULPI receiver, decodes RX CMD status and buffers USB data and per-packet info
// Takes the bus only when the link allows it and dir rises
`timescale 1ns/1ps
`default_nettype none

module ulpiReceiver import ulpiPkg::*; #(
    parameter int DATA_DEPTH = 16,
    parameter int INFO_DEPTH = 4
) (
    input  logic       clk_ULPI,
    input  logic       rst,
    input  logic       readAllow,
    output logic       busy,
    ulpiBusIf.engine   bus,
    output logic [7:0] rxCmd,
    output logic [1:0] lineState,
    output logic [1:0] vbusState,
    output logic       rxActive,
    output logic       rxError,
    output logic       hostDisconnect,
    output logic       rxId,
    input  logic       dataRe,
    input  logic       infoRe,
    output logic [7:0] usbData,
    output infoWordT   usbInfo,
    output logic       dataFull,
    output logic       dataEmpty,
    output logic       infoFull,
    output logic       infoEmpty
);
    logic        rxBusy;
    logic        dirQ;      // dir last cycle, for edge detect
    logic [7:0]  rxCmdQ;    // Last RX CMD
    logic [11:0] byteCnt;   // Bytes in open packet
    logic        errSeen;
    logic        cmdCycle;
    logic        dataCycle;
    logic        dirFall;
    logic        endByCmd;
    logic        pktEnd;
    logic        dataPush;
    logic        infoPush;
    rxEventT     inEvent;   // Event field of incoming byte
    rxEventT     cmdEvent;  // Event field of stored RX CMD
    infoWordT    infoWord;

    assign cmdCycle  = rxBusy && bus.dir && !bus.nxt;
    assign dataCycle = rxBusy && bus.dir && bus.nxt;
    assign dirFall   = rxBusy && !bus.dir;
    assign inEvent   = rxEventT'(bus.dataIn[RX_EVENT_MSB:RX_EVENT_LSB]);
    assign endByCmd  = cmdCycle && (inEvent == EVT_NONE || inEvent == EVT_HOST_DISC);
    assign pktEnd    = (byteCnt != '0) && (endByCmd || dirFall); // RxActive cleared
    assign dataPush  = dataCycle && !dataFull;
    assign infoPush  = pktEnd && !infoFull; // Word lost if info FIFO full

    assign infoWord.errorSeen      = errSeen;
    assign infoWord.lineStateAtEnd = endByCmd ? bus.dataIn[LINE_STATE_MSB:LINE_STATE_LSB]
                                              : rxCmdQ[LINE_STATE_MSB:LINE_STATE_LSB];
    assign infoWord.reserved       = 1'b0;
    assign infoWord.byteCount      = byteCnt;

    always_ff @(posedge clk_ULPI) begin
        if (!rst) begin
            rxBusy  <= 1'b0;
            dirQ    <= 1'b0;
            rxCmdQ  <= '0;
            byteCnt <= '0;
            errSeen <= 1'b0;
        end else begin
            dirQ <= bus.dir;
            if (!rxBusy && readAllow && bus.dir && !dirQ) rxBusy <= 1'b1; // Turnaround
            else if (dirFall) rxBusy <= 1'b0;
            if (cmdCycle) rxCmdQ <= bus.dataIn;
            if (pktEnd) begin
                byteCnt <= '0;
                errSeen <= 1'b0;
            end else if (dataCycle) begin
                byteCnt <= byteCnt + 1'b1;
                if (dataFull) errSeen <= 1'b1; // Byte dropped
            end
        end
    end

    assign cmdEvent       = rxEventT'(rxCmdQ[RX_EVENT_MSB:RX_EVENT_LSB]);
    assign rxCmd          = rxCmdQ;
    assign lineState      = rxCmdQ[LINE_STATE_MSB:LINE_STATE_LSB];
    assign vbusState      = rxCmdQ[VBUS_STATE_MSB:VBUS_STATE_LSB];
    assign rxActive       = (cmdEvent == EVT_RX_ACTIVE) || (cmdEvent == EVT_RX_ERROR);
    assign rxError        = (cmdEvent == EVT_RX_ERROR);
    assign hostDisconnect = (cmdEvent == EVT_HOST_DISC);
    assign rxId           = rxCmdQ[RX_ID_BIT];
    assign busy           = rxBusy;
    assign bus.dataOut    = '0;   // Link stays off the bus while receiving
    assign bus.stp        = 1'b0; // Receive never aborted

    ulpiFifo #(
        .payloadT(logic [7:0]),
        .DEPTH   (DATA_DEPTH)
    ) dataFifo (
        .clk_ULPI(clk_ULPI),
        .rst     (rst),
        .push    (dataPush),
        .pushData(bus.dataIn),
        .pop     (dataRe && !dataEmpty),
        .popData (usbData),
        .full    (dataFull),
        .empty   (dataEmpty)
    );

    ulpiFifo #(
        .payloadT(infoWordT),
        .DEPTH   (INFO_DEPTH)
    ) infoFifo (
        .clk_ULPI(clk_ULPI),
        .rst     (rst),
        .push    (infoPush),
        .pushData(infoWord),
        .pop     (infoRe && !infoEmpty),
        .popData (usbInfo),
        .full    (infoFull),
        .empty   (infoEmpty)
    );

endmodule

`default_nettype wire

// ==== ulpiRegRead.sv ====
// ULPI register-read engine, sends TX CMD and captures the byte after turnaround
// Read value is held on regVal until the next read
`timescale 1ns/1ps
`default_nettype none

module ulpiRegRead import ulpiPkg::*; (
    input  logic       clk_ULPI,
    input  logic       rst,
    input  logic       start,
    input  logic [5:0] regAddr,
    output logic [7:0] regVal,
    output logic       busy,
    ulpiBusIf.engine   bus
);
    typedef enum logic [2:0] {
        R_DONE    = 3'd0,
        R_CMD     = 3'd1, // TX CMD until nxt
        R_TURN    = 3'd2, // Wait for dir, first dir cycle is turnaround
        R_CAPTURE = 3'd3, // PHY drives register byte
        R_WAIT    = 3'd4  // Wait for PHY to release bus
    } rdStateT;

    rdStateT    state;
    logic [5:0] addrQ;

    always_ff @(posedge clk_ULPI) begin
        if (!rst) begin
            state <= R_DONE;
        end else begin
            case (state)
                R_DONE:    if (start) state <= R_CMD;
                R_CMD:     if (bus.nxt) state <= R_TURN;
                R_TURN:    if (bus.dir) state <= R_CAPTURE;
                R_CAPTURE: state <= R_WAIT;
                R_WAIT:    if (!bus.dir) state <= R_DONE;
                default:   state <= R_DONE;
            endcase
        end
    end

    always_ff @(posedge clk_ULPI) begin
        if (start && state == R_DONE) begin
            addrQ <= regAddr;
        end
        if (state == R_CAPTURE) begin
            regVal <= bus.dataIn; // Byte after turnaround
        end
    end

    assign bus.dataOut = (state == R_CMD) ? {TX_CMD_REG_READ, addrQ} : '0;
    assign bus.stp     = 1'b0; // Read is closed by the PHY dropping dir
    assign busy        = (state != R_DONE);

    // Link side must be quiet whenever the PHY owns the bus
    assert property (@(posedge clk_ULPI) disable iff (!rst)
        bus.dir |-> (bus.dataOut == '0));

endmodule

`default_nettype wire

// ==== ulpiRegWrite.sv ====
// ULPI register-write engine, sends TX CMD then data byte then STP
// Started by a one-cycle pulse from the link, busy until the transfer is closed
`timescale 1ns/1ps
`default_nettype none

module ulpiRegWrite import ulpiPkg::*; (
    input  logic       clk_ULPI,
    input  logic       rst,
    input  logic       start,
    input  logic [5:0] regAddr,
    input  logic [7:0] regVal,
    output logic       busy,
    ulpiBusIf.engine   bus
);
    typedef enum logic [1:0] {
        W_DONE = 2'd0, // Waiting for start
        W_CMD  = 2'd1, // TX CMD on bus
        W_DATA = 2'd2, // Register value on bus
        W_STOP = 2'd3  // One cycle of stp
    } wrStateT;

    wrStateT    state;
    logic [5:0] addrQ;
    logic [7:0] valQ;

    always_ff @(posedge clk_ULPI) begin
        if (!rst) begin
            state <= W_DONE;
        end else begin
            case (state)
                W_DONE:  if (start) state <= W_CMD;
                W_CMD:   if (bus.nxt) state <= W_DATA; // PHY took the command
                W_DATA:  if (bus.nxt) state <= W_STOP; // PHY took the value
                W_STOP:  state <= W_DONE;
                default: state <= W_DONE;
            endcase
        end
    end

    always_ff @(posedge clk_ULPI) begin
        if (start && state == W_DONE) begin
            addrQ <= regAddr; // Hold request stable for the transfer
            valQ  <= regVal;
        end
    end

    always_comb begin
        case (state)
            W_CMD:   bus.dataOut = {TX_CMD_REG_WRITE, addrQ};
            W_DATA:  bus.dataOut = valQ;
            default: bus.dataOut = '0; // Idle bus value, also during stp
        endcase
    end

    assign bus.stp = (state == W_STOP);
    assign busy    = (state != W_DONE);

    // PHY must not turn the bus around while we close the transfer
    assert property (@(posedge clk_ULPI) disable iff (!rst) !(bus.stp && bus.dir));

endmodule

`default_nettype wire

// ==== ulpiFifo.sv ====
// Synchronous FIFO with a typed payload and registered read
// popData is valid the cycle after pop, empty and full pushes or pops are ignored
`timescale 1ns/1ps
`default_nettype none

module ulpiFifo #(
    parameter type payloadT = logic [7:0],
    parameter int  DEPTH    = 16
) (
    input  logic    clk_ULPI,
    input  logic    rst,
    input  logic    push,
    input  payloadT pushData,
    input  logic    pop,
    output payloadT popData,
    output logic    full,
    output logic    empty
);
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    payloadT          mem [DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count; // Occupancy
    logic             doPush;
    logic             doPop;

    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1; // Wraps for any depth
    endfunction

    assign full   = (count == CNT_W'(DEPTH));
    assign empty  = (count == '0);
    assign doPush = push && !full;
    assign doPop  = pop && !empty;

    always_ff @(posedge clk_ULPI) begin
        if (!rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) wrPtr <= nextPtr(wrPtr);
            if (doPop) rdPtr <= nextPtr(rdPtr);
            if (doPush && !doPop) count <= count + 1'b1;
            else if (doPop && !doPush) count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk_ULPI) begin
        if (doPush) mem[wrPtr] <= pushData;
        if (doPop) popData <= mem[rdPtr]; // One-cycle read latency
    end

    assert property (@(posedge clk_ULPI) disable iff (!rst) !(push && full))
        else $warning("FIFO push while full");
    assert property (@(posedge clk_ULPI) disable iff (!rst) !(pop && empty))
        else $warning("FIFO pop while empty");

endmodule

`default_nettype wire

// ==== ulpiBusIf.sv ====
// One engine's view of the ULPI bus
// Link side feeds PHY inputs in and picks up the engine's dataOut and stp
`timescale 1ns/1ps
`default_nettype none

interface ulpiBusIf;
    logic       dir;     // PHY owns data bus when high
    logic       nxt;     // PHY throttle
    logic [7:0] dataIn;  // Byte from PHY
    logic [7:0] dataOut; // Byte to PHY
    logic       stp;     // End of link transfer

    modport engine (
        input  dir,
        input  nxt,
        input  dataIn,
        output dataOut,
        output stp
    );

    modport link (
        output dir,
        output nxt,
        output dataIn,
        input  dataOut,
        input  stp
    );
endinterface

`default_nettype wire

// ==== ulpiPkg.sv ====
// Shared ULPI link definitions for controller states, TX CMD prefixes and RX CMD layout
// Imported by the link top, the engines and the receiver
`default_nettype none

package ulpiPkg;

    // Master controller states, also presented on the status port
    typedef enum logic [2:0] {
        START     = 3'd0, // PHY still owns the bus after reset
        IDLE      = 3'd1,
        RECV      = 3'd2,
        REG_WRITE = 3'd3,
        REG_READ  = 3'd4
    } linkStateT;

    localparam logic [1:0] TX_CMD_REG_WRITE = 2'b10; // Sits above 6-bit address
    localparam logic [1:0] TX_CMD_REG_READ  = 2'b11;

    // RX CMD byte field positions
    localparam int LINE_STATE_LSB = 0;
    localparam int LINE_STATE_MSB = 1;
    localparam int VBUS_STATE_LSB = 2;
    localparam int VBUS_STATE_MSB = 3;
    localparam int RX_EVENT_LSB   = 4;
    localparam int RX_EVENT_MSB   = 5;
    localparam int RX_ID_BIT      = 6;

    typedef enum logic [1:0] {
        EVT_NONE      = 2'b00,
        EVT_RX_ACTIVE = 2'b01,
        EVT_HOST_DISC = 2'b10,
        EVT_RX_ERROR  = 2'b11  // RxActive with RxError
    } rxEventT;

    // One per received packet, stored in the info FIFO
    typedef struct packed {
        logic        errorSeen;      // Data byte dropped on full FIFO
        logic [1:0]  lineStateAtEnd; // LineState when packet closed
        logic        reserved;
        logic [11:0] byteCount;      // Bytes seen on the bus
    } infoWordT;

endpackage

`default_nettype wire
